// File: Bender.yml
package:
  name: ex_mem

sources:
  - source/ex_pkg.sv
  - source/ex_alu.sv
  - source/ex_store_align.sv
  - source/ex_stage.sv
  - source/mem_stage.sv
  - source/data_sram.sv
  - source/ex_mem_top.sv
  - target: test
    files:
      - verification/ex_mem_tb.sv

// File: source/data_sram.sv
// byte-masked data memory, one-cycle read latency, addressed by the execute stage
module data_sram import ex_pkg::*; #(
  parameter int SRAM_DEPTH_LOG2 = 8
) (
  input  logic       i_clk,
  input  sram_addr_t i_addr,
  input  logic       i_ren,
  input  logic       i_wen,
  input  wmask_t     i_wmask,
  input  word_t      i_wdata,
  output word_t      o_rdata
);

  localparam int DEPTH = 2 ** SRAM_DEPTH_LOG2;

  word_t                      mem [DEPTH];
  logic [SRAM_DEPTH_LOG2-1:0] word_idx;

  assign word_idx = i_addr[SRAM_DEPTH_LOG2+2:3]; // byte offset dropped

  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      for (int b = 0; b < 8; b++) begin
        if (i_wmask[b]) begin
          mem[word_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
    if (i_ren) begin
      o_rdata <= mem[word_idx];
    end
  end

  // execute must not compute an address past the array
  a_addr_range: assert property (
    @(posedge i_clk) (i_ren || i_wen) |-> (i_addr[31:SRAM_DEPTH_LOG2+3] == '0)
  );

endmodule

// File: source/ex_alu.sv
// integer ALU of the execute stage, with operand select, word ops and the CSR write value
module ex_alu import ex_pkg::*; (
  input  word_t      i_rs1data,
  input  word_t      i_rs2data,
  input  word_t      i_imm,
  input  word_t      i_pc,
  input  word_t      i_csrrdata,
  input  logic       i_src1_sel,
  input  logic [1:0] i_src2_sel,
  input  alu_op_t    i_alu_op,
  input  logic       i_word_cut,
  input  csr_op_t    i_csr_op,
  output word_t      o_alu_result,
  output word_t      o_csr_result
);

  word_t      src1;
  word_t      src2;
  word_t      src1_srl;
  word_t      src1_sra;
  logic [5:0] shamt;
  word_t      raw_result;

  assign src1 = (i_src1_sel == SRC1_PC) ? i_pc : i_rs1data;

  always_comb begin
    case (i_src2_sel)
      SRC2_RS2:  src2 = i_rs2data;
      SRC2_IMM:  src2 = i_imm;
      SRC2_FOUR: src2 = 64'd4;
      default:   src2 = '0;
    endcase
  end

  // word ops shift by five bits and see only the low half
  assign shamt    = i_word_cut ? {1'b0, src2[4:0]} : src2[5:0];
  assign src1_srl = i_word_cut ? {32'b0, src1[31:0]} : src1;
  assign src1_sra = i_word_cut ? {{32{src1[31]}}, src1[31:0]} : src1;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:  raw_result = src1 + src2;
      ALU_SUB:  raw_result = src1 - src2;
      ALU_SLL:  raw_result = src1 << shamt;
      ALU_SLT:  raw_result = {63'b0, $signed(src1) < $signed(src2)};
      ALU_SLTU: raw_result = {63'b0, src1 < src2};
      ALU_XOR:  raw_result = src1 ^ src2;
      ALU_SRL:  raw_result = src1_srl >> shamt;
      ALU_SRA:  raw_result = $signed(src1_sra) >>> shamt;
      ALU_OR:   raw_result = src1 | src2;
      ALU_AND:  raw_result = src1 & src2;
      ALU_SRC2: raw_result = src2;
      default:  raw_result = '0;
    endcase
  end

  assign o_alu_result = i_word_cut ? {{32{raw_result[31]}}, raw_result[31:0]} : raw_result;

  // value written back into the csr
  always_comb begin
    case (i_csr_op)
      CSR_NONE:  o_csr_result = i_csrrdata;
      CSR_WRITE: o_csr_result = i_rs1data;
      CSR_SET:   o_csr_result = i_csrrdata | i_rs1data;
      CSR_CLEAR: o_csr_result = i_csrrdata & ~i_rs1data;
      default:   o_csr_result = i_csrrdata;
    endcase
  end

endmodule

// File: source/ex_mem_top.sv
// execute and memory pipeline top, wires both stages to the data SRAM for the testbench
module ex_mem_top import ex_pkg::*; #(
  parameter int SRAM_DEPTH_LOG2 = 8
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_ds_to_es_valid,
  input  ds_to_es_t i_ds_to_es_bus,
  output logic      o_es_allowin,
  output logic      o_ms_to_ws_valid,
  output ms_to_ws_t o_ms_to_ws_bus,
  input  logic      i_ws_allowin,
  output gpr_addr_t o_es_gpr_rd,
  output csr_addr_t o_es_csr_rd,
  output gpr_addr_t o_ms_gpr_rd
);

  logic       ms_allowin;
  logic       es_to_ms_valid;
  es_to_ms_t  es_to_ms_bus;
  sram_addr_t sram_addr;
  logic       sram_ren;
  logic       sram_wen;
  wmask_t     sram_wmask;
  word_t      sram_wdata;
  word_t      sram_rdata;

  ex_stage u_ex_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_ds_to_es_valid (i_ds_to_es_valid),
    .i_ds_to_es_bus   (i_ds_to_es_bus),
    .i_ms_allowin     (ms_allowin),
    .o_es_allowin     (o_es_allowin),
    .o_es_to_ms_valid (es_to_ms_valid),
    .o_es_to_ms_bus   (es_to_ms_bus),
    .o_sram_addr      (sram_addr),
    .o_sram_ren       (sram_ren),
    .o_sram_wen       (sram_wen),
    .o_sram_wmask     (sram_wmask),
    .o_sram_wdata     (sram_wdata),
    .o_es_gpr_rd      (o_es_gpr_rd),
    .o_es_csr_rd      (o_es_csr_rd)
  );

  mem_stage u_mem_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_es_to_ms_valid (es_to_ms_valid),
    .i_es_to_ms_bus   (es_to_ms_bus),
    .i_sram_rdata     (sram_rdata),
    .i_ws_allowin     (i_ws_allowin),
    .o_ms_allowin     (ms_allowin),
    .o_ms_to_ws_valid (o_ms_to_ws_valid),
    .o_ms_to_ws_bus   (o_ms_to_ws_bus),
    .o_ms_gpr_rd      (o_ms_gpr_rd)
  );

  data_sram #(
    .SRAM_DEPTH_LOG2 (SRAM_DEPTH_LOG2)
  ) u_data_sram (
    .i_clk   (i_clk),
    .i_addr  (sram_addr),
    .i_ren   (sram_ren),
    .i_wen   (sram_wen),
    .i_wmask (sram_wmask),
    .i_wdata (sram_wdata),
    .o_rdata (sram_rdata)
  );

endmodule

// File: source/ex_pkg.sv
// shared widths, op codes and stage records for the execute/memory pipeline, imported by each RTL module
package ex_pkg;

  typedef logic [63:0] word_t;
  typedef logic [4:0]  gpr_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] sram_addr_t;
  typedef logic [7:0]  wmask_t;

  typedef logic [4:0] alu_op_t;
  localparam alu_op_t ALU_ADD  = 5'd0;
  localparam alu_op_t ALU_SUB  = 5'd1;
  localparam alu_op_t ALU_SLL  = 5'd2;
  localparam alu_op_t ALU_SLT  = 5'd3;
  localparam alu_op_t ALU_SLTU = 5'd4;
  localparam alu_op_t ALU_XOR  = 5'd5;
  localparam alu_op_t ALU_SRL  = 5'd6;
  localparam alu_op_t ALU_SRA  = 5'd7;
  localparam alu_op_t ALU_OR   = 5'd8;
  localparam alu_op_t ALU_AND  = 5'd9;
  localparam alu_op_t ALU_SRC2 = 5'd10; // lui

  // bits 1:0 give the size, bit 2 marks an unsigned load
  typedef logic [2:0] mem_op_t;
  localparam mem_op_t MEM_B  = 3'd0;
  localparam mem_op_t MEM_H  = 3'd1;
  localparam mem_op_t MEM_W  = 3'd2;
  localparam mem_op_t MEM_D  = 3'd3;
  localparam mem_op_t MEM_BU = 3'd4;
  localparam mem_op_t MEM_HU = 3'd5;
  localparam mem_op_t MEM_WU = 3'd6;

  typedef logic [2:0] csr_op_t;
  localparam csr_op_t CSR_NONE  = 3'd0;
  localparam csr_op_t CSR_WRITE = 3'd1;
  localparam csr_op_t CSR_SET   = 3'd2;
  localparam csr_op_t CSR_CLEAR = 3'd3;

  localparam logic       SRC1_PC   = 1'b1;
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2;

  typedef struct packed {
    word_t      rs1data;
    word_t      rs2data;
    word_t      csrrdata;
    word_t      imm;
    word_t      pc;
    logic       src1_sel;
    logic [1:0] src2_sel;
    logic       word_cut;
    alu_op_t    alu_op;
    gpr_addr_t  rd;
    csr_addr_t  csr;
    logic       gpr_wen;
    logic       csr_wen;
    logic       mem_ren;
    logic       mem_wen;
    mem_op_t    mem_op;
    logic       csr_inst_sel; // old csr value to gpr
    csr_op_t    csr_op;
    logic       ebreak;
    logic       invalid_inst;
  } ds_to_es_t;

  typedef struct packed {
    gpr_addr_t  rd;
    csr_addr_t  csr;
    logic       gpr_wen;
    logic       csr_wen;
    logic       mem_ren;
    mem_op_t    mem_op;
    logic [2:0] addr_low;
    logic       csr_inst_sel;
    word_t      csrrdata;
    word_t      alu_result;
    word_t      csr_result;
    logic       ebreak;
    logic       invalid_inst;
  } es_to_ms_t;

  typedef struct packed {
    gpr_addr_t rd;
    logic      gpr_wen;
    word_t     wdata;
    csr_addr_t csr;
    logic      csr_wen;
    word_t     csr_wdata;
    logic      ebreak;
    logic      invalid_inst;
  } ms_to_ws_t;

endpackage

// File: source/ex_stage.sv
// execute stage, registers the decoded item, runs the ALU and sends the data SRAM request
module ex_stage import ex_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_ds_to_es_valid,
  input  ds_to_es_t  i_ds_to_es_bus,
  input  logic       i_ms_allowin,
  output logic       o_es_allowin,
  output logic       o_es_to_ms_valid,
  output es_to_ms_t  o_es_to_ms_bus,
  output sram_addr_t o_sram_addr,
  output logic       o_sram_ren,
  output logic       o_sram_wen,
  output wmask_t     o_sram_wmask,
  output word_t      o_sram_wdata,
  output gpr_addr_t  o_es_gpr_rd,
  output csr_addr_t  o_es_csr_rd
);

  logic      es_valid;
  logic      es_leaving;
  ds_to_es_t es_bus_r;
  word_t     alu_result;
  word_t     csr_result;

  assign o_es_allowin     = !es_valid || i_ms_allowin; // single-cycle ALU, always ready
  assign o_es_to_ms_valid = es_valid;
  assign es_leaving       = es_valid && i_ms_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_to_es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid && o_es_allowin) begin
      es_bus_r <= i_ds_to_es_bus;
    end
  end

  ex_alu u_alu (
    .i_rs1data    (es_bus_r.rs1data),
    .i_rs2data    (es_bus_r.rs2data),
    .i_imm        (es_bus_r.imm),
    .i_pc         (es_bus_r.pc),
    .i_csrrdata   (es_bus_r.csrrdata),
    .i_src1_sel   (es_bus_r.src1_sel),
    .i_src2_sel   (es_bus_r.src2_sel),
    .i_alu_op     (es_bus_r.alu_op),
    .i_word_cut   (es_bus_r.word_cut),
    .i_csr_op     (es_bus_r.csr_op),
    .o_alu_result (alu_result),
    .o_csr_result (csr_result)
  );

  ex_store_align u_store_align (
    .i_mem_op   (es_bus_r.mem_op),
    .i_addr_low (alu_result[2:0]), // rs1 + imm
    .i_wdata    (es_bus_r.rs2data),
    .o_wmask    (o_sram_wmask),
    .o_wdata    (o_sram_wdata)
  );

  // request only on the leaving cycle, so a stall never repeats it
  assign o_sram_addr = alu_result[31:0];
  assign o_sram_ren  = es_leaving && es_bus_r.mem_ren;
  assign o_sram_wen  = es_leaving && es_bus_r.mem_wen;

  assign o_es_to_ms_bus.rd           = es_bus_r.rd;
  assign o_es_to_ms_bus.csr          = es_bus_r.csr;
  assign o_es_to_ms_bus.gpr_wen      = es_bus_r.gpr_wen;
  assign o_es_to_ms_bus.csr_wen      = es_bus_r.csr_wen;
  assign o_es_to_ms_bus.mem_ren      = es_bus_r.mem_ren;
  assign o_es_to_ms_bus.mem_op       = es_bus_r.mem_op;
  assign o_es_to_ms_bus.addr_low     = alu_result[2:0];
  assign o_es_to_ms_bus.csr_inst_sel = es_bus_r.csr_inst_sel;
  assign o_es_to_ms_bus.csrrdata     = es_bus_r.csrrdata;
  assign o_es_to_ms_bus.alu_result   = alu_result;
  assign o_es_to_ms_bus.csr_result   = csr_result;
  assign o_es_to_ms_bus.ebreak       = es_bus_r.ebreak;
  assign o_es_to_ms_bus.invalid_inst = es_bus_r.invalid_inst;

  // destinations for the decode stall check
  assign o_es_gpr_rd = {5{es_valid && es_bus_r.gpr_wen}} & es_bus_r.rd;
  assign o_es_csr_rd = {12{es_valid && es_bus_r.csr_wen}} & es_bus_r.csr;

  // decode never sends an item that both loads and stores
  a_ren_wen_excl: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !(o_sram_ren && o_sram_wen)
  );

  // decode keeps its offer steady until execute takes it
  a_ds_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_ds_to_es_valid && !o_es_allowin) |=> (i_ds_to_es_valid && $stable(i_ds_to_es_bus))
  );

endmodule

// File: source/ex_store_align.sv
// store lane placement, turns the memory op and address offset into byte mask and lane data
module ex_store_align import ex_pkg::*; (
  input  mem_op_t    i_mem_op,
  input  logic [2:0] i_addr_low,
  input  word_t      i_wdata,
  output wmask_t     o_wmask,
  output word_t      o_wdata
);

  logic [1:0] size;
  wmask_t     base_mask;

  assign size = i_mem_op[1:0]; // sign bit is meaningless for stores

  always_comb begin
    case (size)
      MEM_B[1:0]: begin
        base_mask = 8'h01;
        o_wdata   = {8{i_wdata[7:0]}};
      end
      MEM_H[1:0]: begin
        base_mask = 8'h03;
        o_wdata   = {4{i_wdata[15:0]}};
      end
      MEM_W[1:0]: begin
        base_mask = 8'h0f;
        o_wdata   = {2{i_wdata[31:0]}};
      end
      default: begin
        base_mask = 8'hff;
        o_wdata   = i_wdata;
      end
    endcase
  end

  // replicated data already sits in every lane, the mask picks the one in use
  assign o_wmask = base_mask << i_addr_low;

endmodule

// File: source/mem_stage.sv
// memory stage, takes the SRAM read data, extends loads and builds the write-back record
module mem_stage import ex_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_es_to_ms_valid,
  input  es_to_ms_t i_es_to_ms_bus,
  input  word_t     i_sram_rdata,
  input  logic      i_ws_allowin,
  output logic      o_ms_allowin,
  output logic      o_ms_to_ws_valid,
  output ms_to_ws_t o_ms_to_ws_bus,
  output gpr_addr_t o_ms_gpr_rd
);

  logic      ms_valid;
  logic      ms_first; // first cycle of the item, sram data is live
  es_to_ms_t ms_bus_r;
  word_t     rdata_hold;
  word_t     rdata;
  word_t     rdata_shift;
  word_t     load_data;

  assign o_ms_allowin     = !ms_valid || i_ws_allowin; // read data already held
  assign o_ms_to_ws_valid = ms_valid;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ms_valid <= 1'b0;
      ms_first <= 1'b0;
    end else begin
      ms_first <= i_es_to_ms_valid && o_ms_allowin;
      if (o_ms_allowin) begin
        ms_valid <= i_es_to_ms_valid;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_to_ms_valid && o_ms_allowin) begin
      ms_bus_r <= i_es_to_ms_bus;
    end
    if (ms_first) begin
      rdata_hold <= i_sram_rdata;
    end
  end

  assign rdata       = ms_first ? i_sram_rdata : rdata_hold;
  assign rdata_shift = rdata >> {ms_bus_r.addr_low, 3'b000};

  always_comb begin
    case (ms_bus_r.mem_op)
      MEM_B:   load_data = {{56{rdata_shift[7]}}, rdata_shift[7:0]};
      MEM_H:   load_data = {{48{rdata_shift[15]}}, rdata_shift[15:0]};
      MEM_W:   load_data = {{32{rdata_shift[31]}}, rdata_shift[31:0]};
      MEM_D:   load_data = rdata_shift;
      MEM_BU:  load_data = {56'b0, rdata_shift[7:0]};
      MEM_HU:  load_data = {48'b0, rdata_shift[15:0]};
      MEM_WU:  load_data = {32'b0, rdata_shift[31:0]};
      default: load_data = rdata_shift;
    endcase
  end

  assign o_ms_to_ws_bus.rd      = ms_bus_r.rd;
  assign o_ms_to_ws_bus.gpr_wen = ms_bus_r.gpr_wen;
  assign o_ms_to_ws_bus.wdata   = ms_bus_r.mem_ren      ? load_data :
                                  ms_bus_r.csr_inst_sel ? ms_bus_r.csrrdata :
                                                          ms_bus_r.alu_result;
  assign o_ms_to_ws_bus.csr          = ms_bus_r.csr;
  assign o_ms_to_ws_bus.csr_wen      = ms_bus_r.csr_wen;
  assign o_ms_to_ws_bus.csr_wdata    = ms_bus_r.csr_result;
  assign o_ms_to_ws_bus.ebreak       = ms_bus_r.ebreak;
  assign o_ms_to_ws_bus.invalid_inst = ms_bus_r.invalid_inst;

  assign o_ms_gpr_rd = {5{ms_valid && ms_bus_r.gpr_wen}} & ms_bus_r.rd;

  // held item keeps its record until write-back takes it
  a_ms_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_ms_to_ws_valid && !i_ws_allowin) |=> (o_ms_to_ws_valid && $stable(o_ms_to_ws_bus))
  );

endmodule

// File: verification/ex_mem_tb.sv
// testbench for the execute/memory pipeline, plays decode and write-back from a trace file
module ex_mem_tb import ex_pkg::*; ();

  localparam int TIMEOUT = 100; // cycles allowed per wait

  logic      clk;
  logic      rst_n;
  logic      ds_valid;
  ds_to_es_t ds_bus;
  logic      es_allowin;
  logic      ms_valid;
  ms_to_ws_t ms_bus;
  logic      ws_allowin;
  gpr_addr_t es_gpr_rd;
  csr_addr_t es_csr_rd;
  gpr_addr_t ms_gpr_rd;

  ds_to_es_t in_q[$];
  ms_to_ws_t exp_q[$];
  int        mismatches;
  int        other_errors;
  int        n_checked;
  integer    seed;
  logic      random_bp; // random write-back back-pressure

  ex_mem_top #(
    .SRAM_DEPTH_LOG2 (8)
  ) dut0 (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_ds_to_es_valid (ds_valid),
    .i_ds_to_es_bus   (ds_bus),
    .o_es_allowin     (es_allowin),
    .o_ms_to_ws_valid (ms_valid),
    .o_ms_to_ws_bus   (ms_bus),
    .i_ws_allowin     (ws_allowin),
    .o_es_gpr_rd      (es_gpr_rd),
    .o_es_csr_rd      (es_csr_rd),
    .o_ms_gpr_rd      (ms_gpr_rd)
  );

  always #10 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp, input string where);
    $display("FAILED %s got %h expected %h (%s)", name, got, exp, where);
    mismatches++;
  endtask

  task automatic load_trace();
    integer      fd;
    integer      n;
    string       tag;
    string       rest;
    logic [63:0] f [20];
    ds_to_es_t   d;
    ms_to_ws_t   e;
    fd = $fopen("verification/ex_mem_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file verification/ex_mem_trace.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", tag);
      if (n != 1) break;
      if (tag == "I") begin
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
        if (n != 20) begin
          $display("malformed input line in the trace after item %0d", in_q.size());
          other_errors++;
          break;
        end
        d.rs1data      = f[0];
        d.rs2data      = f[1];
        d.csrrdata     = f[2];
        d.imm          = f[3];
        d.pc           = f[4];
        d.src1_sel     = f[5][0];
        d.src2_sel     = f[6][1:0];
        d.word_cut     = f[7][0];
        d.alu_op       = f[8][4:0];
        d.rd           = f[9][4:0];
        d.csr          = f[10][11:0];
        d.gpr_wen      = f[11][0];
        d.csr_wen      = f[12][0];
        d.mem_ren      = f[13][0];
        d.mem_wen      = f[14][0];
        d.mem_op       = f[15][2:0];
        d.csr_inst_sel = f[16][0];
        d.csr_op       = f[17][2:0];
        d.ebreak       = f[18][0];
        d.invalid_inst = f[19][0];
        in_q.push_back(d);
      end else if (tag == "E") begin
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
        if (n != 8) begin
          $display("malformed expected line in the trace after record %0d", exp_q.size());
          other_errors++;
          break;
        end
        e.rd           = f[0][4:0];
        e.gpr_wen      = f[1][0];
        e.wdata        = f[2];
        e.csr          = f[3][11:0];
        e.csr_wen      = f[4][0];
        e.csr_wdata    = f[5];
        e.ebreak       = f[6][0];
        e.invalid_inst = f[7][0];
        exp_q.push_back(e);
      end else begin
        n = $fgets(rest, fd); // comment line
      end
    end
    $fclose(fd);
  endtask

  // pipeline empty, no hazards reported
  task automatic check_idle(input string where);
    if (ms_valid !== 1'b0) report_mismatch("o_ms_to_ws_valid", ms_valid, 0, where);
    if (es_gpr_rd !== '0) report_mismatch("o_es_gpr_rd", es_gpr_rd, 0, where);
    if (es_csr_rd !== '0) report_mismatch("o_es_csr_rd", es_csr_rd, 0, where);
    if (ms_gpr_rd !== '0) report_mismatch("o_ms_gpr_rd", ms_gpr_rd, 0, where);
    if (es_allowin !== 1'b1) report_mismatch("o_es_allowin", es_allowin, 1, where);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      ws_allowin <= 1'b0;
    end else if (random_bp) begin
      ws_allowin <= ($random(seed) & 32'h3) != 0;
    end else begin
      ws_allowin <= 1'b1;
    end
  end

  // write-back side, one expected record per transfer
  always @(posedge clk) begin
    ms_to_ws_t exp_rec;
    gpr_addr_t exp_rd;
    string     where;
    if (rst_n && ms_valid && ws_allowin) begin
      if (exp_q.size() == 0) begin
        $display("write-back got a record (rd %h) that the trace does not expect", ms_bus.rd);
        other_errors++;
      end else begin
        exp_rec = exp_q.pop_front();
        exp_rd  = exp_rec.gpr_wen ? exp_rec.rd : 5'd0;
        where   = $sformatf("record %0d", n_checked);
        if (ms_bus.rd !== exp_rec.rd) report_mismatch("rd", ms_bus.rd, exp_rec.rd, where);
        if (ms_bus.gpr_wen !== exp_rec.gpr_wen)
          report_mismatch("gpr_wen", ms_bus.gpr_wen, exp_rec.gpr_wen, where);
        if (ms_bus.wdata !== exp_rec.wdata)
          report_mismatch("wdata", ms_bus.wdata, exp_rec.wdata, where);
        if (ms_bus.csr !== exp_rec.csr) report_mismatch("csr", ms_bus.csr, exp_rec.csr, where);
        if (ms_bus.csr_wen !== exp_rec.csr_wen)
          report_mismatch("csr_wen", ms_bus.csr_wen, exp_rec.csr_wen, where);
        if (ms_bus.csr_wdata !== exp_rec.csr_wdata)
          report_mismatch("csr_wdata", ms_bus.csr_wdata, exp_rec.csr_wdata, where);
        if (ms_bus.ebreak !== exp_rec.ebreak)
          report_mismatch("ebreak", ms_bus.ebreak, exp_rec.ebreak, where);
        if (ms_bus.invalid_inst !== exp_rec.invalid_inst)
          report_mismatch("invalid_inst", ms_bus.invalid_inst, exp_rec.invalid_inst, where);
        if (ms_gpr_rd !== exp_rd) report_mismatch("o_ms_gpr_rd", ms_gpr_rd, exp_rd, where);
        n_checked++;
      end
    end
  end

  initial begin
    int        sent;
    int        wait_cnt;
    ds_to_es_t es_item;
    gpr_addr_t exp_es_rd;
    csr_addr_t exp_es_csr;
    clk          = 1'b0;
    rst_n        = 1'b0;
    ds_valid     = 1'b0;
    ds_bus       = '0;
    ws_allowin   = 1'b0;
    mismatches   = 0;
    other_errors = 0;
    n_checked    = 0;
    seed         = 32'h72f0;
    random_bp    = 1'b1;
    load_trace();
    if (in_q.size() == 0 || in_q.size() != exp_q.size()) begin
      $display("trace holds %0d inputs and %0d expected records", in_q.size(), exp_q.size());
      other_errors++;
    end

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle("after reset");

    // decode side, the next item is offered once the current one is taken
    sent = 0;
    @(posedge clk);
    if (in_q.size() > 0) begin
      ds_valid <= 1'b1;
      ds_bus   <= in_q[0];
    end
    wait_cnt = 0;
    while (sent < in_q.size()) begin
      @(posedge clk);
      if (es_allowin) begin
        sent++;
        wait_cnt = 0;
        if (sent < in_q.size()) begin
          ds_bus <= in_q[sent];
        end else begin
          ds_valid <= 1'b0;
        end
      end else begin
        // execute is stalled and still holds the last item taken
        if (sent > 0) begin
          es_item    = in_q[sent-1];
          exp_es_rd  = es_item.gpr_wen ? es_item.rd : 5'd0;
          exp_es_csr = es_item.csr_wen ? es_item.csr : 12'd0;
          if (es_gpr_rd !== exp_es_rd)
            report_mismatch("o_es_gpr_rd", es_gpr_rd, exp_es_rd, "execute stall");
          if (es_csr_rd !== exp_es_csr)
            report_mismatch("o_es_csr_rd", es_csr_rd, exp_es_csr, "execute stall");
        end
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          $display("timeout, decode item %0d was never accepted", sent);
          other_errors++;
          break;
        end
      end
    end

    wait_cnt = 0;
    while (exp_q.size() > 0 && wait_cnt < TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout, %0d expected write-back records never arrived", exp_q.size());
      other_errors++;
    end

    @(negedge clk);
    random_bp = 1'b0;
    wait_cnt  = 0;
    while (ms_valid && wait_cnt < TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    check_idle("after drain");

    $display("errors: %0d mismatches, %0d other, %0d records checked",
             mismatches, other_errors, n_checked);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verification/ex_mem_trace.txt
# I rs1 rs2 csrr imm pc src1 src2 wcut aluop rd csr gwen cwen mren mwen memop csrsel csrop ebrk inv
# E rd gwen wdata csr cwen csr_wdata ebrk inv   (all columns hex)
I 5 7 0 0 0 0 0 0 0 1 0 1 0 0 0 0 0 0 0 0
E 1 1 c 0 0 0 0 0
I 3 5 0 0 0 0 0 0 1 2 0 1 0 0 0 0 0 0 0 0
E 2 1 fffffffffffffffe 0 0 0 0 0
I 100 0 0 fffffffffffffff0 0 0 1 0 0 3 0 1 0 0 0 0 0 0 0 0
E 3 1 f0 0 0 0 0 0
I ffffffffffffffff 1 0 0 0 0 0 0 3 4 0 1 0 0 0 0 0 0 0 0
E 4 1 1 0 0 0 0 0
I ffffffffffffffff 1 0 0 0 0 0 0 4 5 0 1 0 0 0 0 0 0 0 0
E 5 1 0 0 0 0 0 0
I ff00 ff0 0 0 0 0 0 0 5 6 0 1 0 0 0 0 0 0 0 0
E 6 1 f0f0 0 0 0 0 0
I a0 f 0 0 0 0 0 0 8 7 0 1 0 0 0 0 0 0 0 0
E 7 1 af 0 0 0 0 0
I f0 3c 0 0 0 0 0 0 9 8 0 1 0 0 0 0 0 0 0 0
E 8 1 30 0 0 0 0 0
I 1 3f 0 0 0 0 0 0 2 9 0 1 0 0 0 0 0 0 0 0
E 9 1 8000000000000000 0 0 0 0 0
I 8000000000000000 4 0 0 0 0 0 0 6 a 0 1 0 0 0 0 0 0 0 0
E a 1 0800000000000000 0 0 0 0 0
I 8000000000000000 4 0 0 0 0 0 0 7 b 0 1 0 0 0 0 0 0 0 0
E b 1 f800000000000000 0 0 0 0 0
I 0 0 0 0 1000 1 2 0 0 c 0 1 0 0 0 0 0 0 0 0
E c 1 1004 0 0 0 0 0
I 0 0 0 12345000 0 0 1 0 a d 0 1 0 0 0 0 0 0 0 0
E d 1 12345000 0 0 0 0 0
I 7fffffff 1 0 0 0 0 0 1 0 e 0 1 0 0 0 0 0 0 0 0
E e 1 ffffffff80000000 0 0 0 0 0
I 1 3f 0 0 0 0 0 1 2 f 0 1 0 0 0 0 0 0 0 0
E f 1 ffffffff80000000 0 0 0 0 0
I ffffffff80000000 4 0 0 0 0 0 1 6 10 0 1 0 0 0 0 0 0 0 0
E 10 1 8000000 0 0 0 0 0
I 80000000 4 0 0 0 0 0 1 7 11 0 1 0 0 0 0 0 0 0 0
E 11 1 fffffffff8000000 0 0 0 0 0
# stores into the word at 200, then loads of each size and sign
I 200 1122334455667788 0 0 0 0 1 0 0 0 0 0 0 0 1 3 0 0 0 0
E 0 0 200 0 0 0 0 0
I 200 ab 0 1 0 0 1 0 0 0 0 0 0 0 1 0 0 0 0 0
E 0 0 201 0 0 0 0 0
I 200 1280 0 3 0 0 1 0 0 0 0 0 0 0 1 0 0 0 0 0
E 0 0 203 0 0 0 0 0
I 200 99cdef 0 6 0 0 1 0 0 0 0 0 0 0 1 1 0 0 0 0
E 0 0 206 0 0 0 0 0
I 200 0 0 0 0 0 1 0 0 12 0 1 0 1 0 3 0 0 0 0
E 12 1 cdef33448066ab88 0 0 0 0 0
I 200 119abcdef0 0 c 0 0 1 0 0 0 0 0 0 0 1 2 0 0 0 0
E 0 0 20c 0 0 0 0 0
I 200 0 0 c 0 0 1 0 0 18 0 1 0 1 0 2 0 0 0 0
E 18 1 ffffffff9abcdef0 0 0 0 0 0
I 200 0 0 3 0 0 1 0 0 13 0 1 0 1 0 0 0 0 0 0
E 13 1 ffffffffffffff80 0 0 0 0 0
I 200 0 0 3 0 0 1 0 0 14 0 1 0 1 0 4 0 0 0 0
E 14 1 80 0 0 0 0 0
I 200 0 0 6 0 0 1 0 0 15 0 1 0 1 0 1 0 0 0 0
E 15 1 ffffffffffffcdef 0 0 0 0 0
I 200 0 0 6 0 0 1 0 0 16 0 1 0 1 0 5 0 0 0 0
E 16 1 cdef 0 0 0 0 0
I 200 0 0 0 0 0 1 0 0 17 0 1 0 1 0 1 0 0 0 0
E 17 1 ffffffffffffab88 0 0 0 0 0
I 200 0 0 c 0 0 1 0 0 19 0 1 0 1 0 6 0 0 0 0
E 19 1 9abcdef0 0 0 0 0 0
# csr write, set and clear with the old value to the gpr
I 1234 0 aa 0 0 0 0 0 0 1a 300 1 1 0 0 0 1 1 0 0
E 1a 1 aa 300 1 1234 0 0
I f0 0 a5a5 0 0 0 0 0 0 1b 305 1 1 0 0 0 1 2 0 0
E 1b 1 a5a5 305 1 a5f5 0 0
I ff 0 1234 0 0 0 0 0 0 1c 341 1 1 0 0 0 1 3 0 0
E 1c 1 1234 341 1 1200 0 0
I 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0
E 0 0 0 0 0 0 1 0
I 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
E 0 0 0 0 0 0 0 1

// File: vlog.f
source/ex_pkg.sv
source/ex_alu.sv
source/ex_store_align.sv
source/ex_stage.sv
source/mem_stage.sv
source/data_sram.sv
source/ex_mem_top.sv
verification/ex_mem_tb.sv
